/* common/hi_iso14443a_pkg.sv */
// ISO14443-A receive and sniff front end, shared definitions
// holds the mode codes, the protocol constants and the structs passed between blocks
package hi_iso14443a_pkg;

	// mode codes as the ARM writes them, the unlisted codes behave as idle
	typedef enum logic [2:0] {
		SNIFFER       = 3'd0,
		READER_LISTEN = 3'd3,
		READER_MOD    = 3'd4
	} ht_mode_e;

	// --------------------
	// widths
	localparam int ADC_W    = 8;
	localparam int TIMER_W  = 7;
	localparam int FILTER_W = 11;

	// --------------------
	// reader side thresholds, all in ADC counts or carrier ticks
	localparam int HYST_HIGH        = 16;
	localparam int HYST_LOW         = 8;
	localparam int FIELD_PRESENT    = 192;
	localparam int FIELD_LOSS_TICKS = 4095;
	localparam int DEEP_ON_TICKS    = 7;
	localparam int DEEP_OFF_TICKS   = 255;

	// tag side, minimum filter swing of each sign that counts as an edge
	localparam int EDGE_DETECT_THRESHOLD = 5;
	localparam int LISTEN_WINDOW_PHASE   = 4;
	localparam int SNIFF_WINDOW_OFFSET   = 3;

	// decoded carrier timer phase, one struct so every block sees the same strobes
	typedef struct packed {
		logic [TIMER_W-1:0] count;
		logic               bit_slot;
		logic               byte_load;
		logic               sniff_shift;
	} carrier_phase_t;

	// shaped reader signal with its rising edge flag
	typedef struct packed {
		logic level;
		logic rising;
	} reader_sig_t;

endpackage

/* logic/carrier_timer.sv */
// carrier timer
// counts carrier ticks 0 to 127 and decodes the phase strobes of the SSP transfer
`timescale 1ns/1ps

module carrier_timer (
	input  logic                            pck0,
	input  logic                            fdt_reset,
	output hi_iso14443a_pkg::carrier_phase_t phase
);

	logic [hi_iso14443a_pkg::TIMER_W-1:0] count;

	// free running, the wrap from 127 to 0 comes from the width
	always_ff @(posedge pck0)
	begin
		if (fdt_reset)
			count <= '0;
		else
			count <= count + 1'b1;
	end

	// one tick every 16, the sample point of reader and tag bits
	assign phase.count       = count;
	assign phase.bit_slot    = (count[3:0] == 4'd0);
	// last tick of a 64 tick frame, the sniff byte is built here
	assign phase.byte_load   = (count[5:0] == 6'd63);
	// double rate shift, but not on the tick right after a load
	assign phase.sniff_shift = (count[2:0] == 3'd0) && (count[5:0] != 6'd0);

endmodule

/* reader_rx/reader_pause_detector.sv */
// reader pause detector
// Schmitt trigger on the ADC sample that turns the reader's 100 % pauses into a clean
// level, with recovery to carrier on when the field stays weak, and a rising edge flag
`timescale 1ns/1ps

module reader_pause_detector (
	input  logic                                pck0,
	input  logic                                fdt_reset,
	input  logic [hi_iso14443a_pkg::ADC_W-1:0]  adc_d,
	output hi_iso14443a_pkg::reader_sig_t       reader
);

	logic        level;
	logic        level_d;
	logic [11:0] weak_count;

	always_ff @(posedge pck0)
	begin
		if (fdt_reset)
		begin
			level      <= 1'b0;
			level_d    <= 1'b0;
			weak_count <= '0;
		end
		else
		begin
			level_d <= level;

			// hysteresis, the band between the thresholds keeps the old level
			if (adc_d >= hi_iso14443a_pkg::HYST_HIGH)
				level <= 1'b1;
			else if (adc_d < hi_iso14443a_pkg::HYST_LOW)
				level <= 1'b0;

			// a long stretch of weak field means the reader is gone, so report
			// an unmodulated carrier. this assignment comes last and wins
			if (adc_d >= hi_iso14443a_pkg::FIELD_PRESENT)
				weak_count <= '0;
			else if (weak_count == 12'(hi_iso14443a_pkg::FIELD_LOSS_TICKS))
			begin
				weak_count <= '0;
				level      <= 1'b1;
			end
			else
				weak_count <= weak_count + 1'b1;
		end
	end

	assign reader.level  = level;
	// high for the one tick after level went from 0 to 1
	assign reader.rising = level & ~level_d;

endmodule

/* reader_rx/reader_activity_detector.sv */
// reader activity detector
// marks a reader as sending while it modulates the carrier deeply and releases
// the mark after a long stretch with the carrier present
`timescale 1ns/1ps

module reader_activity_detector (
	input  logic                               pck0,
	input  logic                               fdt_reset,
	input  logic [hi_iso14443a_pkg::ADC_W-1:0] adc_d,
	output logic                               reader_active
);

	logic [2:0] zero_count;
	logic [7:0] quiet_count;

	always_ff @(posedge pck0)
	begin
		if (fdt_reset)
		begin
			reader_active <= 1'b0;
			zero_count    <= '0;
			quiet_count   <= '0;
		end
		else if (adc_d == '0)
		begin
			// carrier fully off, the 8th zero in a row means deep modulation
			quiet_count <= '0;
			if (zero_count == 3'(hi_iso14443a_pkg::DEEP_ON_TICKS))
				reader_active <= 1'b1;
			else
				zero_count <= zero_count + 1'b1;
		end
		else
		begin
			// carrier present, after 256 such ticks the reader is probably waiting for the tag
			zero_count <= '0;
			if (quiet_count == 8'(hi_iso14443a_pkg::DEEP_OFF_TICKS))
				reader_active <= 1'b0;
			else
				quiet_count <= quiet_count + 1'b1;
		end
	end

endmodule

/* tag_rx/tag_edge_filter.sv */
// tag edge filter
// gaussian derivative over five samples of the ADC stream, peaks at the edges
// of the tag's load modulation
`timescale 1ns/1ps

module tag_edge_filter (
	input  logic                                        pck0,
	input  logic                                        fdt_reset,
	input  logic        [hi_iso14443a_pkg::ADC_W-1:0]   adc_d,
	output logic signed [hi_iso14443a_pkg::FILTER_W-1:0] filtered
);

	// prev_1 is the newest stored sample, prev_4 the oldest
	logic [hi_iso14443a_pkg::ADC_W-1:0] prev_1, prev_2, prev_3, prev_4;
	logic [hi_iso14443a_pkg::ADC_W+1:0] old_sum;
	logic [hi_iso14443a_pkg::ADC_W+1:0] new_sum;

	always_ff @(posedge pck0)
	begin
		if (fdt_reset)
		begin
			prev_1 <= '0;
			prev_2 <= '0;
			prev_3 <= '0;
			prev_4 <= '0;
		end
		else
		begin
			prev_4 <= prev_3;
			prev_3 <= prev_2;
			prev_2 <= prev_1;
			prev_1 <= adc_d;
		end
	end

	// weights 2 1 0 -1 -2 from oldest to current, prev_2 drops out
	assign old_sum  = {prev_4, 1'b0} + prev_3;
	assign new_sum  = {adc_d, 1'b0} + prev_1;
	// both sums are unsigned, one extra bit makes the difference signed
	assign filtered = $signed({1'b0, old_sum}) - $signed({1'b0, new_sum});

endmodule

/* tag_rx/tag_load_detector.sv */
// tag load modulation detector
// searches each 16 tick window for the steepest edge of each sign and decides
// one tag modulation bit per window
`timescale 1ns/1ps

module tag_load_detector (
	input  logic                                        pck0,
	input  logic                                        fdt_reset,
	input  hi_iso14443a_pkg::ht_mode_e                  mod_type,
	input  hi_iso14443a_pkg::carrier_phase_t            phase,
	input  hi_iso14443a_pkg::reader_sig_t               reader,
	input  logic                                        reader_active,
	input  logic signed [hi_iso14443a_pkg::FILTER_W-1:0] filtered,
	output logic                                        tag_bit
);

	logic        [3:0]                          window;
	logic signed [hi_iso14443a_pkg::FILTER_W-1:0] pos_peak;
	logic signed [hi_iso14443a_pkg::FILTER_W-1:0] neg_peak;

	// --------------------
	// window phase
	always_ff @(posedge pck0)
	begin
		if (fdt_reset)
			window <= '0;
		else if (mod_type == hi_iso14443a_pkg::READER_LISTEN)
			// our own reader edge sits at a fixed timer phase, so the tag answer does too
			window <= 4'(hi_iso14443a_pkg::LISTEN_WINDOW_PHASE);
		else if (mod_type == hi_iso14443a_pkg::SNIFFER && reader.rising && reader_active)
			// end of a foreign reader pause, the tag answer follows a fixed delay later
			window <= phase.count[3:0] - 4'(hi_iso14443a_pkg::SNIFF_WINDOW_OFFSET);
	end

	// --------------------
	// peak search and decision
	always_ff @(posedge pck0)
	begin
		if (fdt_reset)
		begin
			tag_bit  <= 1'b0;
			pos_peak <= '0;
			neg_peak <= '0;
		end
		else if (phase.count[3:0] == window)
		begin
			// a modulating tag gives a falling and a rising edge in the window, in any order
			tag_bit <= (pos_peak > hi_iso14443a_pkg::EDGE_DETECT_THRESHOLD) &&
				(neg_peak < -hi_iso14443a_pkg::EDGE_DETECT_THRESHOLD);
			pos_peak <= '0;
			neg_peak <= '0;
		end
		else if (filtered > 0)
		begin
			if (filtered > pos_peak)
				pos_peak <= filtered;
		end
		else if (filtered < neg_peak)
			neg_peak <= filtered;
	end

endmodule

/* ssp_link/arm_serializer.sv */
// ARM serializer
// collects reader and tag bits, builds the sniff byte and selects the ssp_din bit
`timescale 1ns/1ps

module arm_serializer (
	input  logic                             pck0,
	input  logic                             fdt_reset,
	input  hi_iso14443a_pkg::ht_mode_e       mod_type,
	input  hi_iso14443a_pkg::carrier_phase_t phase,
	input  hi_iso14443a_pkg::reader_sig_t    reader,
	input  logic                             reader_active,
	input  logic                             tag_bit,
	output logic                             ssp_din
);

	logic [3:0] reader_hist;
	logic [3:0] tag_hist;
	logic [7:0] to_arm;
	logic [7:0] to_arm_next;
	logic       send_bit;
	logic       send_next;
	logic       din_next;

	// --------------------
	// next byte and bit, ssp_din follows them so it is valid at the ssp_clk rising edge
	always_comb
	begin
		to_arm_next = to_arm;
		if (mod_type == hi_iso14443a_pkg::SNIFFER)
		begin
			// while a reader talks there is no tag answer worth sending
			if (phase.byte_load)
				to_arm_next = {reader_hist, reader_active ? 4'b0000 : tag_hist};
			else if (phase.sniff_shift)
				to_arm_next = {to_arm[6:0], 1'b0};
		end

		send_next = phase.bit_slot ? tag_bit : send_bit;

		case (mod_type)
			hi_iso14443a_pkg::SNIFFER:       din_next = to_arm_next[7];
			hi_iso14443a_pkg::READER_LISTEN: din_next = send_next;
			default:                         din_next = 1'b0;
		endcase
	end

	always_ff @(posedge pck0)
	begin
		if (fdt_reset)
		begin
			reader_hist <= '0;
			tag_hist    <= '0;
			to_arm      <= '0;
			send_bit    <= 1'b0;
			ssp_din     <= 1'b0;
		end
		else
		begin
			// four samples of each side per byte, oldest ends up in the top bit
			if (phase.bit_slot)
			begin
				reader_hist <= {reader_hist[2:0], reader.level};
				tag_hist    <= {tag_hist[2:0], tag_bit};
			end
			to_arm   <= to_arm_next;
			send_bit <= send_next;
			ssp_din  <= din_next;
		end
	end

endmodule

/* ssp_link/ssp_port.sv */
// SSP port
// generates ssp_clk and ssp_frame from the carrier timer, samples the ARM's
// ssp_dout and gates the HF carrier drive with it
`timescale 1ns/1ps

module ssp_port (
	input  logic                             pck0,
	input  logic                             fdt_reset,
	input  hi_iso14443a_pkg::ht_mode_e       mod_type,
	input  hi_iso14443a_pkg::carrier_phase_t phase,
	input  logic                             ck_1356megb,
	input  logic                             ssp_dout,
	output logic                             ssp_clk,
	output logic                             ssp_frame,
	output logic                             pwr_hi
);

	logic coil;

	always_ff @(posedge pck0)
	begin
		if (fdt_reset)
		begin
			ssp_clk   <= 1'b0;
			ssp_frame <= 1'b0;
			coil      <= 1'b0;
		end
		else
		begin
			coil <= ssp_dout;
			if (mod_type == hi_iso14443a_pkg::SNIFFER)
			begin
				// 8 tick clock, frame every 64 ticks
				if (phase.count[2:0] == 3'd0)
					ssp_clk <= 1'b1;
				else if (phase.count[2:0] == 3'd4)
					ssp_clk <= 1'b0;
				if (phase.count[5:0] == 6'd0)
					ssp_frame <= 1'b1;
				else if (phase.count[5:0] == 6'd8)
					ssp_frame <= 1'b0;
			end
			else
			begin
				// 16 tick clock, frame every 128 ticks
				if (phase.bit_slot)
					ssp_clk <= 1'b1;
				else if (phase.count[3:0] == 4'd8)
					ssp_clk <= 1'b0;
				if (phase.count == 7'd7)
					ssp_frame <= 1'b1;
				else if (phase.count == 7'd23)
					ssp_frame <= 1'b0;
			end
		end
	end

	// a 1 from the ARM is a reader pause in READER_MOD, the listen mode keeps the field on
	assign pwr_hi = ck_1356megb &
		(((mod_type == hi_iso14443a_pkg::READER_MOD) & ~coil) |
		(mod_type == hi_iso14443a_pkg::READER_LISTEN));

endmodule

/* logic/hi_iso14443a.sv */
// ISO14443-A HF front end, receive and sniff path
// connects the carrier timer, the reader and tag receivers and the ARM link
`timescale 1ns/1ps

module hi_iso14443a (
	input  logic                               pck0,
	input  logic                               fdt_reset,
	input  logic [hi_iso14443a_pkg::ADC_W-1:0] adc_d,
	input  logic                               ck_1356megb,
	input  logic                               ssp_dout,
	input  hi_iso14443a_pkg::ht_mode_e         mod_type,
	output logic                               ssp_clk,
	output logic                               ssp_frame,
	output logic                               ssp_din,
	output logic                               pwr_hi
);

	hi_iso14443a_pkg::carrier_phase_t              phase;
	hi_iso14443a_pkg::reader_sig_t                 reader;
	logic                                          reader_active;
	logic signed [hi_iso14443a_pkg::FILTER_W-1:0]  filtered;
	logic                                          tag_bit;

	// --------------------
	// timing and reader side
	carrier_timer u_timer (
		.pck0      (pck0),
		.fdt_reset (fdt_reset),
		.phase     (phase)
	);

	reader_pause_detector u_pause (
		.pck0      (pck0),
		.fdt_reset (fdt_reset),
		.adc_d     (adc_d),
		.reader    (reader)
	);

	reader_activity_detector u_activity (
		.pck0          (pck0),
		.fdt_reset     (fdt_reset),
		.adc_d         (adc_d),
		.reader_active (reader_active)
	);

	// --------------------
	// tag side
	tag_edge_filter u_filter (
		.pck0      (pck0),
		.fdt_reset (fdt_reset),
		.adc_d     (adc_d),
		.filtered  (filtered)
	);

	tag_load_detector u_load (
		.pck0          (pck0),
		.fdt_reset     (fdt_reset),
		.mod_type      (mod_type),
		.phase         (phase),
		.reader        (reader),
		.reader_active (reader_active),
		.filtered      (filtered),
		.tag_bit       (tag_bit)
	);

	// --------------------
	// link to the ARM
	arm_serializer u_serializer (
		.pck0          (pck0),
		.fdt_reset     (fdt_reset),
		.mod_type      (mod_type),
		.phase         (phase),
		.reader        (reader),
		.reader_active (reader_active),
		.tag_bit       (tag_bit),
		.ssp_din       (ssp_din)
	);

	ssp_port u_ssp (
		.pck0        (pck0),
		.fdt_reset   (fdt_reset),
		.mod_type    (mod_type),
		.phase       (phase),
		.ck_1356megb (ck_1356megb),
		.ssp_dout    (ssp_dout),
		.ssp_clk     (ssp_clk),
		.ssp_frame   (ssp_frame),
		.pwr_hi      (pwr_hi)
	);

endmodule

/* sim/tb_clock.sv */
// testbench clock source
// free running pck0 with a 100 ns period, one carrier sample tick per rising edge
`timescale 1ns/1ps

module tb_clock (
	output logic pck0
);

	localparam int HALF_PERIOD = 50;

	initial
	begin
		pck0 = 1'b0;
		forever
			#(HALF_PERIOD) pck0 = ~pck0;
	end

endmodule

/* sim/tb_hi_iso14443a.sv */
// testbench of the ISO14443-A receive and sniff front end
// directed tests of reset state, SSP timing, carrier gating, tag detection,
// sniff bytes and field-loss recovery
`timescale 1ns/1ps

module tb_hi_iso14443a;

	localparam int DRIVE_DELAY  = 10;
	localparam int RESET_CYCLES = 3;
	// cycle budget of each test, from reset to field loss
	localparam int TEST_CYCLES     = 20 + 2000 + 2000 + 2000 + 3000 + 16000;
	localparam int WATCHDOG_CYCLES = TEST_CYCLES * 6 / 5;
	localparam logic [31:0] LCG_SEED = 32'h467f_a97d;

	logic                       pck0;
	logic                       fdt_reset;
	logic [7:0]                 adc_d;
	logic                       ck_1356megb;
	logic                       ssp_dout;
	hi_iso14443a_pkg::ht_mode_e mod_type;
	logic                       ssp_clk;
	logic                       ssp_frame;
	logic                       ssp_din;
	logic                       pwr_hi;

	int          cycle_count;
	logic        subcarrier_on;
	logic [31:0] lcg_state;

	tb_clock u_clock (
		.pck0 (pck0)
	);

	hi_iso14443a DUT (
		.pck0        (pck0),
		.fdt_reset   (fdt_reset),
		.adc_d       (adc_d),
		.ck_1356megb (ck_1356megb),
		.ssp_dout    (ssp_dout),
		.mod_type    (mod_type),
		.ssp_clk     (ssp_clk),
		.ssp_frame   (ssp_frame),
		.ssp_din     (ssp_din),
		.pwr_hi      (pwr_hi)
	);

	// --------------------
	// helpers

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic expect_equal(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected)
		begin
			$display("CHECK FAILED at %0t ns: %s, got %0h, expected %0h",
				$time, what, actual, expected);
			$display("sim failed");
			$fatal(1, "first mismatch ends the run");
		end
	endtask

	// one tick, inputs change shortly after the rising edge where all outputs are stable
	task automatic advance();
		@(posedge pck0);
		#(DRIVE_DELAY);
		cycle_count++;
		// square wave of 16 ticks, like a tag loading the field at the subcarrier rate
		if (subcarrier_on)
			adc_d = cycle_count[3] ? 8'd200 : 8'd40;
	endtask

	task automatic skip_cycles(input int n);
		repeat (n)
			advance();
	endtask

	task automatic apply_reset();
		fdt_reset = 1'b1;
		skip_cycles(RESET_CYCLES);
		fdt_reset = 1'b0;
	endtask

	// waits for ssp_clk or ssp_frame to change to the given level and counts the ticks
	task automatic wait_edge(input logic use_frame, input logic to_level, output int cycles);
		logic prev;
		logic now;
		cycles = 0;
		now = use_frame ? ssp_frame : ssp_clk;
		do
		begin
			prev = now;
			advance();
			cycles++;
			now = use_frame ? ssp_frame : ssp_clk;
		end
		while (!(prev != to_level && now == to_level));
	endtask

	// the frame rises together with the clock, so that edge carries the top bit
	task automatic read_byte(output logic [7:0] data);
		int unused;
		wait_edge(1'b1, 1'b1, unused);
		data[7] = ssp_din;
		for (int i = 6; i >= 0; i--)
		begin
			wait_edge(1'b0, 1'b1, unused);
			data[i] = ssp_din;
		end
	endtask

	// --------------------
	// tests

	task automatic check_reset_state();
		apply_reset();
		expect_equal(ssp_clk, 1'b0, "ssp_clk after reset");
		expect_equal(ssp_frame, 1'b0, "ssp_frame after reset");
		expect_equal(ssp_din, 1'b0, "ssp_din after reset");
		expect_equal(pwr_hi, 1'b0, "pwr_hi after reset");
	endtask

	task automatic measure_ssp_rates(input hi_iso14443a_pkg::ht_mode_e mode, input int clk_gap,
		input int frame_gap, input int frame_high);
		int high_cycles;
		int low_cycles;
		int gap;
		mod_type = mode;
		skip_cycles(4);
		// the first frame after a mode change only synchronises
		wait_edge(1'b1, 1'b1, gap);
		wait_edge(1'b1, 1'b0, high_cycles);
		wait_edge(1'b1, 1'b1, low_cycles);
		expect_equal(high_cycles, frame_high, "ssp_frame high time");
		expect_equal(high_cycles + low_cycles, frame_gap, "ssp_frame period");
		wait_edge(1'b0, 1'b1, gap);
		repeat (4)
		begin
			wait_edge(1'b0, 1'b1, gap);
			expect_equal(gap, clk_gap, "ssp_clk period");
		end
	endtask

	task automatic verify_carrier_gating();
		logic dout_bit;
		mod_type = hi_iso14443a_pkg::READER_MOD;
		for (int seg = 0; seg < 8; seg++)
		begin
			lcg_state = lcg_next(lcg_state);
			dout_bit = lcg_state[16];
			ssp_dout = dout_bit;
			for (int i = 0; i < 20; i++)
			begin
				advance();
				ck_1356megb = ~ck_1356megb;
				#1;
				// the coil register needs a tick to follow ssp_dout
				if (i >= 2)
					expect_equal(pwr_hi, ck_1356megb & ~dout_bit, "pwr_hi in READER_MOD");
			end
		end

		mod_type = hi_iso14443a_pkg::READER_LISTEN;
		repeat (20)
		begin
			advance();
			ck_1356megb = ~ck_1356megb;
			#1;
			expect_equal(pwr_hi, ck_1356megb, "pwr_hi in READER_LISTEN");
		end

		// SNIFFER and the idle codes keep the carrier off
		for (int code = 0; code < 8; code++)
		begin
			if (code != int'(hi_iso14443a_pkg::READER_LISTEN) &&
				code != int'(hi_iso14443a_pkg::READER_MOD))
			begin
				mod_type = hi_iso14443a_pkg::ht_mode_e'(code[2:0]);
				repeat (8)
				begin
					advance();
					ck_1356megb = ~ck_1356megb;
					#1;
					expect_equal(pwr_hi, 1'b0, "pwr_hi with the carrier off");
				end
			end
		end
		ssp_dout = 1'b0;
	endtask

	task automatic detect_tag_load();
		int unused;
		mod_type = hi_iso14443a_pkg::READER_LISTEN;
		subcarrier_on = 1'b1;
		skip_cycles(64);
		repeat (8)
		begin
			wait_edge(1'b0, 1'b1, unused);
			expect_equal(ssp_din, 1'b1, "ssp_din with tag modulation");
		end

		// steady field, so the filter stays flat and no edge is found
		subcarrier_on = 1'b0;
		adc_d = 8'd200;
		skip_cycles(64);
		repeat (4)
		begin
			wait_edge(1'b0, 1'b1, unused);
			expect_equal(ssp_din, 1'b0, "ssp_din without tag modulation");
		end
	endtask

	task automatic read_sniff_bytes();
		logic [7:0] data;
		mod_type = hi_iso14443a_pkg::SNIFFER;
		adc_d = 8'd255;
		skip_cycles(300);
		// reader nibble all ones, tag nibble empty
		repeat (3)
		begin
			read_byte(data);
			expect_equal(data, 8'hF0, "sniff byte with the carrier on");
		end

		// a long pause sets reader_active, which also masks the tag nibble
		adc_d = 8'd0;
		skip_cycles(100);
		repeat (2)
		begin
			read_byte(data);
			expect_equal(data, 8'h00, "sniff byte during a reader pause");
		end
	endtask

	task automatic recover_field_loss();
		logic [7:0] data;
		int         change_cycle;
		mod_type = hi_iso14443a_pkg::SNIFFER;
		adc_d = 8'd0;
		// start the weak field count from zero
		apply_reset();
		skip_cycles(20);
		adc_d = 8'd12;
		change_cycle = cycle_count;

		// a byte read takes at most 120 ticks, so the last one ends before tick 3900
		while (cycle_count - change_cycle < 3900 - 120)
		begin
			read_byte(data);
			expect_equal(data, 8'h00, "sniff byte before field-loss recovery");
		end

		while (cycle_count - change_cycle < 4300)
			advance();
		// the forced level stays since 12 lies between the thresholds
		repeat (3)
		begin
			read_byte(data);
			expect_equal(data, 8'hF0, "sniff byte after field-loss recovery");
		end
	endtask

	// --------------------
	// sequence and watchdog

	initial
	begin
		fdt_reset     = 1'b1;
		adc_d         = 8'd255;
		ck_1356megb   = 1'b0;
		ssp_dout      = 1'b0;
		mod_type      = hi_iso14443a_pkg::SNIFFER;
		subcarrier_on = 1'b0;
		cycle_count   = 0;
		lcg_state     = LCG_SEED;

		check_reset_state();
		measure_ssp_rates(hi_iso14443a_pkg::SNIFFER, 8, 64, 8);
		measure_ssp_rates(hi_iso14443a_pkg::READER_LISTEN, 16, 128, 16);
		verify_carrier_gating();
		detect_tag_load();
		read_sniff_bytes();
		recover_field_loss();

		$display("sim passed");
		$finish;
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES)
			@(posedge pck0);
		$display("timeout, the tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
		$display("sim failed");
		$fatal(1, "watchdog expired");
	end

endmodule

/* hi_iso14443a.f */
common/hi_iso14443a_pkg.sv
logic/carrier_timer.sv
reader_rx/reader_pause_detector.sv
reader_rx/reader_activity_detector.sv
tag_rx/tag_edge_filter.sv
tag_rx/tag_load_detector.sv
ssp_link/arm_serializer.sv
ssp_link/ssp_port.sv
logic/hi_iso14443a.sv
sim/tb_clock.sv
sim/tb_hi_iso14443a.sv

/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator, runs it and looks for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module tb_hi_iso14443a -f hi_iso14443a.f \
	-o sim_tb > build.log 2>&1 && ./obj_dir/sim_tb > sim.log 2>&1
grep -qx "sim passed" sim.log && echo "PASS" || { echo "FAIL, see build.log and sim.log"; exit 1; }
